// File: rtl/edt_pkg.sv
package edt_pkg;

	////////////////////////////////////////////////////////////
	// Widths fixed by the ring polynomial and channel count
	////////////////////////////////////////////////////////////

	// x32 + x27 + x21 + x16 + x10 + x5 + 1
	localparam int RING_W     = 32;
	// Tester channels, one per injection point
	localparam int NUM_INJ    = 5;
	// Scan chains fed by the phase shifter
	localparam int NUM_CHAINS = 8;

	typedef logic [RING_W-1:0]     ring_state_t;
	typedef logic [NUM_INJ-1:0]    inj_t;
	typedef logic [NUM_CHAINS-1:0] chains_t;

	// Phase shifter taps, three ring bits per chain
	// Each chain bit is the XOR of its three ring bits
	localparam int PS_TAPS [NUM_CHAINS][3] = '{
		'{ 0, 11, 23},
		'{ 3, 14, 29},
		'{ 6, 17, 26},
		'{ 9, 20, 31},
		'{ 1, 12, 27},
		'{ 4, 19, 24},
		'{ 7, 15, 30},
		'{10, 22, 28}
	};

	// One beat towards the scan chains
	typedef struct packed {
		logic    en;
		logic    last;
		chains_t data;
	} scan_beat_t;

	// Pattern controller states
	typedef enum logic [1:0] {IDLE, WARMUP, SHIFT} edt_state_t;

endpackage

// File: rtl/ring_generator.sv
`timescale 1ns/1ps

module ring_generator import edt_pkg::*; (
	input  logic        i_clk,
	input  logic        i_rst,
	input  logic        i_clear,
	input  logic        i_advance,
	input  inj_t        i_inj,
	output ring_state_t o_state
);

	ring_state_t ring_q;
	ring_state_t ring_next;

	////////////////////////////////////////////////////////////
	// Next state of the ring
	////////////////////////////////////////////////////////////

	always_comb begin
		// Upper half, injection points on 2, 5, 8, 11, 14
		ring_next[0]  = ring_q[1];
		ring_next[1]  = ring_q[2];
		ring_next[2]  = ring_q[3] ^ i_inj[0];
		ring_next[3]  = ring_q[4];
		ring_next[4]  = ring_q[5];
		ring_next[5]  = ring_q[6] ^ i_inj[1];
		ring_next[6]  = ring_q[7];
		ring_next[7]  = ring_q[8];
		ring_next[8]  = ring_q[9] ^ i_inj[2];
		ring_next[9]  = ring_q[10];
		ring_next[10] = ring_q[11];
		ring_next[11] = ring_q[12] ^ i_inj[3];
		ring_next[12] = ring_q[13];
		ring_next[13] = ring_q[14];
		ring_next[14] = ring_q[15] ^ i_inj[4];
		ring_next[15] = ring_q[16];
		// Lower half, polynomial feedback taps
		ring_next[16] = ring_q[17];
		ring_next[17] = ring_q[18] ^ ring_q[13];
		ring_next[18] = ring_q[19];
		ring_next[19] = ring_q[20];
		ring_next[20] = ring_q[21] ^ ring_q[11];
		ring_next[21] = ring_q[22];
		ring_next[22] = ring_q[23];
		ring_next[23] = ring_q[24] ^ ring_q[8];
		ring_next[24] = ring_q[25];
		ring_next[25] = ring_q[26] ^ ring_q[5];
		ring_next[26] = ring_q[27];
		ring_next[27] = ring_q[28];
		ring_next[28] = ring_q[29] ^ ring_q[2];
		ring_next[29] = ring_q[30];
		ring_next[30] = ring_q[31];
		// Ring closes back onto the top
		ring_next[31] = ring_q[0];
	end

	////////////////////////////////////////////////////////////
	// Ring register
	////////////////////////////////////////////////////////////

	// Clear wins over advance, otherwise hold
	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			ring_q <= '0;
		end else if (i_clear) begin
			ring_q <= '0;
		end else if (i_advance) begin
			ring_q <= ring_next;
		end
	end

	assign o_state = ring_q;

endmodule

// File: rtl/phase_shifter.sv
`timescale 1ns/1ps

module phase_shifter import edt_pkg::*; (
	input  logic        i_clk,
	input  logic        i_rst,
	input  ring_state_t i_state,
	input  logic        i_shift,
	input  logic        i_last,
	output scan_beat_t  o_beat
);

	chains_t    ps_bits;
	scan_beat_t beat_q;

	////////////////////////////////////////////////////////////
	// XOR network
	////////////////////////////////////////////////////////////

	// Three ring taps per chain
	always_comb begin
		for (int c = 0; c < NUM_CHAINS; c++) begin
			ps_bits[c] = i_state[PS_TAPS[c][0]]
				^ i_state[PS_TAPS[c][1]]
				^ i_state[PS_TAPS[c][2]];
		end
	end

	////////////////////////////////////////////////////////////
	// Beat register
	////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			beat_q <= '0;
		end else begin
			// Strobes follow the controller one cycle later
			beat_q.en   <= i_shift;
			beat_q.last <= i_shift & i_last;
			// Chains stay quiet outside of shift
			if (i_shift) begin
				beat_q.data <= ps_bits;
			end
		end
	end

	assign o_beat = beat_q;

endmodule

// File: rtl/edt_controller.sv
`timescale 1ns/1ps

module edt_controller import edt_pkg::*; #(
	parameter int WARMUP_CYCLES = 6,
	parameter int CHAIN_LEN     = 16
) (
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_start,
	output logic o_clear,
	output logic o_advance,
	output logic o_shift,
	output logic o_last,
	output logic o_busy
);

	// Counter sized for the longer of the two phases
	localparam int MAX_CNT = (WARMUP_CYCLES > CHAIN_LEN) ? WARMUP_CYCLES : CHAIN_LEN;
	localparam int CNT_W   = (MAX_CNT > 1) ? $clog2(MAX_CNT) : 1;

	typedef logic [CNT_W-1:0] cnt_t;

	localparam cnt_t WARMUP_LOAD = cnt_t'(WARMUP_CYCLES - 1);
	localparam cnt_t SHIFT_LOAD  = cnt_t'(CHAIN_LEN - 1);

	edt_state_t state_q;
	cnt_t       cnt_q;
	logic       start_ok;
	logic       cnt_done;

	////////////////////////////////////////////////////////////
	// Decode
	////////////////////////////////////////////////////////////

	// Start only honoured while idle
	assign start_ok = (state_q == IDLE) && i_start;
	assign cnt_done = (cnt_q == '0);

	////////////////////////////////////////////////////////////
	// State and counter
	////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			state_q <= IDLE;
			cnt_q   <= '0;
		end else begin
			case (state_q)
				IDLE: begin
					if (start_ok) begin
						state_q <= WARMUP;
						cnt_q   <= WARMUP_LOAD;
					end
				end
				WARMUP: begin
					// Seed the ring, then reload for shift
					if (cnt_done) begin
						state_q <= SHIFT;
						cnt_q   <= SHIFT_LOAD;
					end else begin
						cnt_q <= cnt_q - 1'b1;
					end
				end
				SHIFT: begin
					// Back to idle on the final beat
					if (cnt_done) begin
						state_q <= IDLE;
					end else begin
						cnt_q <= cnt_q - 1'b1;
					end
				end
				default: begin
					state_q <= IDLE;
					cnt_q   <= '0;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Outputs
	////////////////////////////////////////////////////////////

	// Clear lands on the start edge itself
	assign o_clear   = start_ok;
	assign o_advance = (state_q == WARMUP) || (state_q == SHIFT);
	assign o_shift   = (state_q == SHIFT);
	assign o_last    = (state_q == SHIFT) && cnt_done;
	// High from start edge until last beat shows
	assign o_busy    = (state_q != IDLE);

endmodule

// File: rtl/edt_decompressor.sv
`timescale 1ns/1ps

module edt_decompressor import edt_pkg::*; #(
	parameter int WARMUP_CYCLES = 6,
	parameter int CHAIN_LEN     = 16
) (
	input  logic       i_clk,
	input  logic       i_rst,
	input  logic       i_start,
	input  inj_t       i_inj,
	output scan_beat_t o_scan,
	output logic       o_busy
);

	logic        ring_clear;
	logic        ring_advance;
	logic        shift_pending;
	logic        last_pending;
	ring_state_t ring_state;

	// Pattern sequencing
	edt_controller #(
		.WARMUP_CYCLES (WARMUP_CYCLES),
		.CHAIN_LEN     (CHAIN_LEN)
	) u_ctrl (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_start   (i_start),
		.o_clear   (ring_clear),
		.o_advance (ring_advance),
		.o_shift   (shift_pending),
		.o_last    (last_pending),
		.o_busy    (o_busy)
	);

	// Channel bits folded into the ring
	ring_generator u_ring (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_clear   (ring_clear),
		.i_advance (ring_advance),
		.i_inj     (i_inj),
		.o_state   (ring_state)
	);

	// Ring state spread over the chains
	phase_shifter u_ps (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_state (ring_state),
		.i_shift (shift_pending),
		.i_last  (last_pending),
		.o_beat  (o_scan)
	);

endmodule

// File: sim/edt_model.svh
`ifndef EDT_MODEL_SVH
`define EDT_MODEL_SVH

////////////////////////////////////////////////////////////
// Reference model of the ring and phase shifter
////////////////////////////////////////////////////////////

// Channel injection sites, channel 0 first
localparam int INJ_POS [NUM_INJ] = '{2, 5, 8, 11, 14};
// Feedback pairs from the polynomial
localparam int FB_DST [5] = '{17, 20, 23, 25, 28};
localparam int FB_SRC [5] = '{13, 11, 8, 5, 2};

// One advance of the ring
function automatic ring_state_t ring_step(input ring_state_t s, input inj_t inj);
	ring_state_t n;
	int          i;
	// Plain rotate towards bit 0
	n = {s[0], s[RING_W-1:1]};
	for (i = 0; i < NUM_INJ; i++) begin
		n[INJ_POS[i]] = n[INJ_POS[i]] ^ inj[i];
	end
	// Taps read the old state
	for (i = 0; i < 5; i++) begin
		n[FB_DST[i]] = n[FB_DST[i]] ^ s[FB_SRC[i]];
	end
	return n;
endfunction

// Chain bits for one ring state
function automatic chains_t phase_shift(input ring_state_t s);
	chains_t c;
	int      ch;
	int      t;
	for (ch = 0; ch < NUM_CHAINS; ch++) begin
		c[ch] = 1'b0;
		for (t = 0; t < 3; t++) begin
			c[ch] = c[ch] ^ s[PS_TAPS[ch][t]];
		end
	end
	return c;
endfunction

////////////////////////////////////////////////////////////
// Compare tasks
////////////////////////////////////////////////////////////

// Single strobe or flag
task automatic check_flag(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		abort_run($sformatf("ERROR %s: got 0x%0h expected 0x%0h", name, got, exp));
	end
endtask

// Chain data of one beat
task automatic check_chains(input string name, input chains_t got, input chains_t exp);
	if (got !== exp) begin
		abort_run($sformatf("ERROR %s: got 0x%02h expected 0x%02h", name, got, exp));
	end
endtask

`endif

// File: sim/edt_decompressor_tb.sv
`timescale 1ns/1ps

module edt_decompressor_tb import edt_pkg::*; ();

	localparam int WARMUP_CYCLES = 6;
	localparam int CHAIN_LEN     = 16;

	// Run limit, six patterns plus reset and idle margin
	localparam int PAT_CYCLES     = WARMUP_CYCLES + CHAIN_LEN + 4;
	localparam int NUM_PATTERNS   = 6;
	localparam int TIMEOUT_CYCLES = NUM_PATTERNS * PAT_CYCLES + 40;

	// Channel data kinds
	localparam int KIND_ZERO = 0;
	localparam int KIND_ONE  = 1;
	localparam int KIND_RAND = 2;

	logic       i_clk;
	logic       i_rst;
	logic       i_start;
	inj_t       i_inj;
	scan_beat_t o_scan;
	logic       o_busy;

	integer  seed = 32'h1156_2617;
	int      cycle_count = 0;
	// Data the chains should currently hold
	chains_t held_data;

	edt_decompressor #(
		.WARMUP_CYCLES (WARMUP_CYCLES),
		.CHAIN_LEN     (CHAIN_LEN)
	) uut (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_start (i_start),
		.i_inj   (i_inj),
		.o_scan  (o_scan),
		.o_busy  (o_busy)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1, "Simulation stopped");
	endtask

	`include "edt_model.svh"

	initial begin
		i_clk = 1'b0;
		forever #50 i_clk = ~i_clk;
	end

	always @(posedge i_clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			abort_run($sformatf("Timeout: tests still running after %0d cycles", cycle_count));
		end
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	// Outputs settle just after the edge
	task automatic wait_edge();
		@(posedge i_clk);
		#1;
	endtask

	function automatic inj_t next_inj(input int kind, input int e);
		case (kind)
			KIND_ZERO: return '0;
			KIND_ONE:  return (e == 1) ? inj_t'(1) : inj_t'(0);
			default:   return inj_t'($random(seed));
		endcase
	endfunction

	// Quiet cycles, channels toggling
	task automatic idle_cycles(input int n);
		int i;
		for (i = 0; i < n; i++) begin
			i_start = 1'b0;
			i_inj   = inj_t'($random(seed));
			wait_edge();
			check_flag("o_scan.en", o_scan.en, 1'b0);
			check_flag("o_scan.last", o_scan.last, 1'b0);
			check_flag("o_busy", o_busy, 1'b0);
			check_chains("o_scan.data", o_scan.data, held_data);
		end
	endtask

	// Full pattern from the start edge, returns in the last beat cycle
	task automatic run_pattern(input int kind, input bit poke_busy);
		ring_state_t model_ring;
		inj_t        inj;
		int          last_edge;
		int          e;
		last_edge = WARMUP_CYCLES + CHAIN_LEN;
		// Edge 0 clears, channels ignored
		model_ring = '0;
		i_start    = 1'b1;
		i_inj      = inj_t'($random(seed));
		wait_edge();
		check_flag("o_busy", o_busy, 1'b1);
		check_flag("o_scan.en", o_scan.en, 1'b0);
		check_flag("o_scan.last", o_scan.last, 1'b0);
		check_chains("o_scan.data", o_scan.data, held_data);
		for (e = 1; e <= last_edge; e++) begin
			inj = next_inj(kind, e);
			// Starts while busy must be dropped
			i_start = poke_busy && (e == 2 || e == last_edge);
			i_inj   = inj;
			// Shift edges latch the state before the advance
			if (e > WARMUP_CYCLES) begin
				held_data = phase_shift(model_ring);
			end
			model_ring = ring_step(model_ring, inj);
			wait_edge();
			// Strobe per edge pins the beat count to CHAIN_LEN
			check_flag("o_scan.en", o_scan.en, e > WARMUP_CYCLES);
			check_flag("o_scan.last", o_scan.last, e == last_edge);
			check_flag("o_busy", o_busy, e < last_edge);
			check_chains("o_scan.data", o_scan.data, held_data);
		end
		i_start = 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////

	task automatic reset_and_idle();
		check_flag("o_scan.en", o_scan.en, 1'b0);
		check_flag("o_scan.last", o_scan.last, 1'b0);
		check_flag("o_busy", o_busy, 1'b0);
		check_chains("o_scan.data", o_scan.data, '0);
		idle_cycles(8);
	endtask

	// Ring stays empty, all beats zero
	task automatic zero_pattern();
		run_pattern(KIND_ZERO, 1'b0);
		idle_cycles(2);
	endtask

	// One seed bit, free running ring
	task automatic single_bit_pattern();
		run_pattern(KIND_ONE, 1'b0);
		idle_cycles(2);
	endtask

	task automatic random_pattern();
		run_pattern(KIND_RAND, 1'b0);
		idle_cycles(2);
	endtask

	// Starts in the last beat cycle, last one also poked while busy
	task automatic back_to_back_patterns();
		run_pattern(KIND_RAND, 1'b0);
		run_pattern(KIND_RAND, 1'b0);
		run_pattern(KIND_RAND, 1'b1);
		idle_cycles(2);
	endtask

	initial begin
		i_rst     = 1'b1;
		i_start   = 1'b0;
		i_inj     = '0;
		held_data = '0;
		repeat (4) @(posedge i_clk);
		#1;
		i_rst = 1'b0;
		reset_and_idle();
		zero_pattern();
		single_bit_pattern();
		random_pattern();
		back_to_back_patterns();
		$display("NO ERRORS");
		$finish;
	end

endmodule

// File: edt_decompressor.f
+incdir+sim
rtl/edt_pkg.sv
rtl/ring_generator.sv
rtl/phase_shifter.sv
rtl/edt_controller.sv
rtl/edt_decompressor.sv
sim/edt_decompressor_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the decompressor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
	--top-module edt_decompressor_tb \
	-f edt_decompressor.f
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/Vedt_decompressor_tb
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

exit 0
